//--- xcvr_reconfig_pkg.sv
package xcvr_reconfig_pkg;

    // Bus widths
    localparam int DATA_W      = 16;        // Host and channel data word
    localparam int CHNL_ADDR_W = 11;        // Hard channel register address

    // Soft CSR register indices
    localparam logic [3:0] CSR_STATUS  = 4'd0;  // Read-only status word
    localparam logic [3:0] CSR_RST_OVR = 4'd1;  // Reset override controls
    localparam logic [3:0] CSR_LTRLTD  = 4'd2;  // LTR/LTD override controls
    localparam logic [3:0] CSR_SLPBK   = 4'd3;  // Serial loopback enable

    // Word address as seen by the soft CSR file
    typedef struct packed {
        logic       sel;                    // 1 selects soft CSR
        logic [6:0] unused;                 // Not decoded
        logic [3:0] idx;                    // Register index
    } csr_addr_t;

    // Word address as seen by the hard channel bus
    typedef struct packed {
        logic                   sel;        // 0 selects hard channel
        logic [CHNL_ADDR_W-1:0] addr;       // Channel register address
    } chnl_addr_t;

    // Bit 11 picks the path, the rest decodes per target
    typedef union packed {
        csr_addr_t  csr;
        chnl_addr_t chnl;
    } reconfig_addr_u;

    // Request from decode to either target
    typedef struct packed {
        reconfig_addr_u    addr;
        logic              we;              // 1 for write
        logic [DATA_W-1:0] wdata;
    } reconfig_req_t;

    // Response from a target to the return stage
    typedef struct packed {
        logic              done;            // One-cycle completion
        logic [DATA_W-1:0] rdata;
    } reconfig_resp_t;

    // Hard channel register bus
    typedef struct packed {
        logic                   wr;         // Write strobe
        logic                   rd;         // Read strobe
        logic [CHNL_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]      wdata;
    } chnl_bus_t;

    // Reset override register, bit 0 is tx_en
    typedef struct packed {
        logic rx_ana_val;                   // Forced CDR and rxpma reset_n
        logic rx_dig_val;                   // Forced rx PCS reset_n
        logic rx_en;                        // Override rx resets
        logic tx_val;                       // Forced tx PCS reset_n
        logic tx_en;                        // Override tx reset
    } rst_ovr_t;

endpackage

//--- reconfig_req_decode.sv
module reconfig_req_decode (
    input  logic                              avmm_clk,
    input  logic                              avmm_reset,
    // Wishbone classic slave side
    input  logic                              wb_cyc,
    input  logic                              wb_stb,
    input  logic                              wb_we,
    input  logic [xcvr_reconfig_pkg::CHNL_ADDR_W:0] wb_adr,
    input  logic [xcvr_reconfig_pkg::DATA_W-1:0]    wb_dat_w,
    input  logic                              wb_ack,      // Ends the busy window
    // Target requests
    output xcvr_reconfig_pkg::reconfig_req_t  csr_req,
    output logic                              csr_valid,
    output xcvr_reconfig_pkg::reconfig_req_t  chnl_req,
    output logic                              chnl_valid
);
    import xcvr_reconfig_pkg::*;

    reconfig_req_t req_q;       // Captured host request
    logic          busy;        // One transaction in flight
    logic          accept;      // Host request taken this edge
    logic          acc_q;       // Accepted last edge, classify now

    // Classic cycle, new request only once the last ack is gone
    assign accept = wb_cyc && wb_stb && !busy;

    always_ff @(posedge avmm_clk or posedge avmm_reset) begin
        if (avmm_reset) begin
            busy       <= 1'b0;
            acc_q      <= 1'b0;
            csr_valid  <= 1'b0;
            chnl_valid <= 1'b0;
        end else begin
            acc_q      <= accept;
            // Exactly one target sees the pulse
            csr_valid  <= acc_q &&  req_q.addr.csr.sel;
            chnl_valid <= acc_q && !req_q.addr.chnl.sel;
            if (accept) begin
                busy <= 1'b1;
            end else if (wb_ack) begin
                busy <= 1'b0;   // stb still high at this edge, not re-taken
            end
        end
    end

    // Request payload, held stable for the whole transaction
    always_ff @(posedge avmm_clk) begin
        if (accept) begin
            req_q.addr  <= wb_adr;
            req_q.we    <= wb_we;
            req_q.wdata <= wb_dat_w;
        end
    end

    // Both targets share the same captured request
    assign csr_req  = req_q;
    assign chnl_req = req_q;

    // No second acceptance until the host has seen its ack
    a_single_txn: assert property (
        @(posedge avmm_clk) disable iff (avmm_reset)
        accept |=> (!accept until_with wb_ack)
    );

    // Ack only ever closes an accepted transaction
    a_ack_in_txn: assert property (
        @(posedge avmm_clk) disable iff (avmm_reset)
        wb_ack |-> busy
    );

endmodule

//--- reconfig_csr_regs.sv
module reconfig_csr_regs (
    input  logic                              avmm_clk,
    input  logic                              avmm_reset,
    input  xcvr_reconfig_pkg::reconfig_req_t  req,
    input  logic                              valid,
    // Status sources
    input  logic                              prbs_done,
    input  logic                              prbs_err,
    // Core-driven resets, active low
    input  logic                              in_tx_rst_n,
    input  logic                              in_rx_rst_n,
    input  logic                              in_rx_cdr_rst_n,
    input  logic                              in_rxpma_rst_n,
    // Core-driven lock controls
    input  logic                              in_ltr,
    input  logic                              in_ltd,
    input  logic                              seriallpbken,    // Loopback pin
    output xcvr_reconfig_pkg::reconfig_resp_t resp,
    // Steered resets to PCS and PMA
    output logic                              out_tx_rst_n,
    output logic                              out_rx_rst_n,
    output logic                              out_rx_cdr_rst_n,
    output logic                              out_rxpma_rst_n,
    output logic                              csr2pcs_ltr,
    output logic                              csr2pma_ltd,
    output logic                              pma_seriallpbken
);
    import xcvr_reconfig_pkg::*;

    rst_ovr_t          rst_ovr_q;       // Reset override register
    logic [2:0]        ltrltd_q;        // Bit 0 enable, bit 1 LTR, bit 2 LTD
    logic              slpbk_q;         // Soft loopback enable
    logic [3:0]        idx;             // Decoded register index
    logic [DATA_W-1:0] status_word;
    logic [DATA_W-1:0] rd_word;
    logic [DATA_W-1:0] rdata_q;
    logic              done_q;

    assign idx = req.addr.csr.idx;

    // Live status, reset bits reported as active high
    assign status_word = DATA_W'({~in_rx_rst_n, ~in_tx_rst_n, prbs_err, prbs_done});

    // Read mux, zero-extended
    always_comb begin
        case (idx)
            CSR_STATUS:  rd_word = status_word;
            CSR_RST_OVR: rd_word = DATA_W'(rst_ovr_q);
            CSR_LTRLTD:  rd_word = DATA_W'(ltrltd_q);
            CSR_SLPBK:   rd_word = DATA_W'(slpbk_q);
            default:     rd_word = '0;     // Unmapped
        endcase
    end

    // Control registers
    always_ff @(posedge avmm_clk or posedge avmm_reset) begin
        if (avmm_reset) begin
            rst_ovr_q <= '0;
            ltrltd_q  <= '0;
            slpbk_q   <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= valid;                // Answer one cycle after request
            if (valid && req.we) begin
                case (idx)
                    CSR_RST_OVR: rst_ovr_q <= rst_ovr_t'(req.wdata[4:0]);
                    CSR_LTRLTD:  ltrltd_q  <= req.wdata[2:0];
                    CSR_SLPBK:   slpbk_q   <= req.wdata[0];
                    default:     ;          // Status and holes ignore writes
                endcase
            end
        end
    end

    // Read data payload
    always_ff @(posedge avmm_clk) begin
        if (valid) begin
            rdata_q <= req.we ? '0 : rd_word;   // Writes return zero
        end
    end

    assign resp = '{done: done_q, rdata: rdata_q};

    // Reset overrides, forced value wins while enabled
    assign out_tx_rst_n     = rst_ovr_q.tx_en ? rst_ovr_q.tx_val     : in_tx_rst_n;
    assign out_rx_rst_n     = rst_ovr_q.rx_en ? rst_ovr_q.rx_dig_val : in_rx_rst_n;
    // One analog value covers both CDR and rxpma
    assign out_rx_cdr_rst_n = rst_ovr_q.rx_en ? rst_ovr_q.rx_ana_val : in_rx_cdr_rst_n;
    assign out_rxpma_rst_n  = rst_ovr_q.rx_en ? rst_ovr_q.rx_ana_val : in_rxpma_rst_n;

    // LTR/LTD override
    assign csr2pcs_ltr = ltrltd_q[0] ? ltrltd_q[1] : in_ltr;
    assign csr2pma_ltd = ltrltd_q[0] ? ltrltd_q[2] : in_ltd;

    // Either source enables loopback
    assign pma_seriallpbken = slpbk_q | seriallpbken;

endmodule

//--- chnl_bus_bridge.sv
module chnl_bus_bridge #(
    parameter int num_blocks = 8            // Channel blocks behind the bus
) (
    input  logic                              avmm_clk,
    input  logic                              avmm_reset,
    input  xcvr_reconfig_pkg::reconfig_req_t  req,
    input  logic                              valid,
    // Block answers, valid during the strobe cycle
    input  logic [num_blocks-1:0]             blk_select,
    input  logic [num_blocks-1:0][xcvr_reconfig_pkg::DATA_W-1:0] blk_readdata,
    output xcvr_reconfig_pkg::chnl_bus_t      chnl,
    output xcvr_reconfig_pkg::reconfig_resp_t resp
);
    import xcvr_reconfig_pkg::*;

    logic                   wr_q;           // Write strobe phase
    logic                   rd_q;           // Read strobe phase
    logic [CHNL_ADDR_W-1:0] addr_q;
    logic [DATA_W-1:0]      wdata_q;
    logic [DATA_W-1:0]      blk_word;       // Priority-selected block data
    logic [DATA_W-1:0]      rdata_q;
    logic                   done_q;         // Sample phase complete

    // Lowest-numbered selected block wins, none gives zero
    always_comb begin
        blk_word = '0;
        for (int i = num_blocks - 1; i >= 0; i--) begin
            if (blk_select[i]) begin
                blk_word = blk_readdata[i];
            end
        end
    end

    // Strobe phase, then sample phase
    always_ff @(posedge avmm_clk or posedge avmm_reset) begin
        if (avmm_reset) begin
            wr_q   <= 1'b0;
            rd_q   <= 1'b0;
            done_q <= 1'b0;
        end else begin
            wr_q   <= valid &&  req.we;
            rd_q   <= valid && !req.we;
            done_q <= wr_q || rd_q;         // Writes finish alongside reads
        end
    end

    // Bus payload and sampled read word
    always_ff @(posedge avmm_clk) begin
        if (valid) begin
            addr_q  <= req.addr.chnl.addr;  // Low 11 address bits
            wdata_q <= req.wdata;
        end
        if (rd_q) begin
            rdata_q <= blk_word;
        end else if (wr_q) begin
            rdata_q <= '0;
        end
    end

    assign chnl = '{wr: wr_q, rd: rd_q, addr: addr_q, wdata: wdata_q};
    assign resp = '{done: done_q, rdata: rdata_q};

    // Strobes exclusive and one cycle wide
    a_strobe_shape: assert property (
        @(posedge avmm_clk) disable iff (avmm_reset)
        (chnl.wr || chnl.rd) |-> !(chnl.wr && chnl.rd) ##1 !(chnl.wr || chnl.rd)
    );

endmodule

//--- reconfig_resp_return.sv
module reconfig_resp_return (
    input  logic                              avmm_clk,
    input  logic                              avmm_reset,
    input  xcvr_reconfig_pkg::reconfig_resp_t csr_resp,
    input  xcvr_reconfig_pkg::reconfig_resp_t chnl_resp,
    output logic                              wb_ack,
    output logic [xcvr_reconfig_pkg::DATA_W-1:0] wb_dat_r
);
    import xcvr_reconfig_pkg::*;

    logic              any_done;            // Either target finished
    logic [DATA_W-1:0] dat_nxt;             // Merged read word

    assign any_done = csr_resp.done || chnl_resp.done;
    assign dat_nxt  = csr_resp.done ? csr_resp.rdata : chnl_resp.rdata;

    // Acknowledge, one cycle per done
    always_ff @(posedge avmm_clk or posedge avmm_reset) begin
        if (avmm_reset) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= any_done;
        end
    end

    // Read word held until the next completion
    always_ff @(posedge avmm_clk) begin
        if (any_done) begin
            wb_dat_r <= dat_nxt;
        end
    end

    // Host sees one ack per transaction
    a_ack_single: assert property (
        @(posedge avmm_clk) disable iff (avmm_reset)
        wb_ack |=> !wb_ack
    );

    // Decode steers each request to one target only
    a_done_excl: assert property (
        @(posedge avmm_clk) disable iff (avmm_reset)
        !(csr_resp.done && chnl_resp.done)
    );

endmodule

//--- xcvr_reconfig_top.sv
module xcvr_reconfig_top #(
    parameter int num_blocks = 8
) (
    input  logic                                  avmm_clk,
    input  logic                                  avmm_reset,
    // Wishbone classic host port
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [xcvr_reconfig_pkg::CHNL_ADDR_W:0] wb_adr,
    input  logic [xcvr_reconfig_pkg::DATA_W-1:0]  wb_dat_w,
    output logic [xcvr_reconfig_pkg::DATA_W-1:0]  wb_dat_r,
    output logic                                  wb_ack,
    // Status and core-driven controls
    input  logic                                  prbs_done,
    input  logic                                  prbs_err,
    input  logic                                  in_tx_rst_n,
    input  logic                                  in_rx_rst_n,
    input  logic                                  in_rx_cdr_rst_n,
    input  logic                                  in_rxpma_rst_n,
    input  logic                                  in_ltr,
    input  logic                                  in_ltd,
    input  logic                                  seriallpbken,
    // Steered controls
    output logic                                  out_tx_rst_n,
    output logic                                  out_rx_rst_n,
    output logic                                  out_rx_cdr_rst_n,
    output logic                                  out_rxpma_rst_n,
    output logic                                  csr2pcs_ltr,
    output logic                                  csr2pma_ltd,
    output logic                                  pma_seriallpbken,
    // Hard channel register bus
    output xcvr_reconfig_pkg::chnl_bus_t          chnl,
    input  logic [num_blocks-1:0]                 blk_select,
    input  logic [num_blocks-1:0][xcvr_reconfig_pkg::DATA_W-1:0] blk_readdata
);
    import xcvr_reconfig_pkg::*;

    reconfig_req_t  csr_req;
    reconfig_req_t  chnl_req;
    logic           csr_valid;
    logic           chnl_valid;
    reconfig_resp_t csr_resp;
    reconfig_resp_t chnl_resp;

    reconfig_req_decode u_decode (
        .avmm_clk, .avmm_reset,
        .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w,
        .wb_ack,                            // Feedback closes busy
        .csr_req, .csr_valid, .chnl_req, .chnl_valid
    );

    reconfig_csr_regs u_csr (
        .avmm_clk, .avmm_reset,
        .req   (csr_req),
        .valid (csr_valid),
        .prbs_done, .prbs_err,
        .in_tx_rst_n, .in_rx_rst_n, .in_rx_cdr_rst_n, .in_rxpma_rst_n,
        .in_ltr, .in_ltd, .seriallpbken,
        .resp  (csr_resp),
        .out_tx_rst_n, .out_rx_rst_n, .out_rx_cdr_rst_n, .out_rxpma_rst_n,
        .csr2pcs_ltr, .csr2pma_ltd, .pma_seriallpbken
    );

    chnl_bus_bridge #(
        .num_blocks (num_blocks)
    ) u_bridge (
        .avmm_clk, .avmm_reset,
        .req   (chnl_req),
        .valid (chnl_valid),
        .blk_select, .blk_readdata,
        .chnl,
        .resp  (chnl_resp)
    );

    reconfig_resp_return u_return (
        .avmm_clk, .avmm_reset,
        .csr_resp, .chnl_resp,
        .wb_ack, .wb_dat_r
    );

endmodule

//--- tb_reconfig_checker.sv
module tb_reconfig_checker #(
    parameter int num_blocks = 8
) (
    input  logic                                    avmm_clk,
    input  logic                                    avmm_reset,
    input  logic                                    wb_cyc,
    input  logic                                    wb_stb,
    input  logic                                    wb_we,
    input  logic [xcvr_reconfig_pkg::CHNL_ADDR_W:0] wb_adr,
    input  logic [xcvr_reconfig_pkg::DATA_W-1:0]    wb_dat_w,
    input  logic [xcvr_reconfig_pkg::DATA_W-1:0]    wb_dat_r,
    input  logic                                    wb_ack,
    input  xcvr_reconfig_pkg::chnl_bus_t            chnl,
    input  logic [num_blocks-1:0]                   blk_select,
    input  logic [num_blocks-1:0][xcvr_reconfig_pkg::DATA_W-1:0] blk_readdata,
    input  logic [8:0]                              pins,   // done err tx rx cdr pma ltr ltd lpbk
    input  logic [6:0]                              outs,   // tx rx cdr pma ltr ltd lpbk
    output int                                      errors
);
    timeunit 1ns;
    timeprecision 1ps;
    import xcvr_reconfig_pkg::*;

    logic [4:0]        ovr_q;                   // Shadow reset override
    logic [2:0]        lt_q;                    // Shadow LTR/LTD
    logic              lb_q;                    // Shadow loopback
    logic              busy, ack_q, we_q;       // Open host transaction
    logic [11:0]       adr_q;
    logic [DATA_W-1:0] dat_q, exp_q;
    int                cycle, acc_cycle, strobes;
    int                err_cnt = 0;

    assign errors = err_cnt;

    task automatic mismatch(input string msg);
        $display("mismatch at time %0t: %s", $time, msg);
        err_cnt++;
    endtask

    // Steered outputs from shadow CSRs and live pins
    function automatic logic [6:0] expected_outs();
        return {(ovr_q[0] ? ovr_q[1] : pins[6]), (ovr_q[2] ? ovr_q[3] : pins[5]),
                (ovr_q[2] ? ovr_q[4] : pins[4]), (ovr_q[2] ? ovr_q[4] : pins[3]),
                (lt_q[0] ? lt_q[1] : pins[2]), (lt_q[0] ? lt_q[2] : pins[1]),
                (lb_q | pins[0])};
    endfunction

    // Read word per address, channel side is the lowest selected block
    function automatic logic [DATA_W-1:0] expected_data(input logic [11:0] adr);
        if (!adr[11]) begin
            for (int i = 0; i < num_blocks; i++) begin
                if (blk_select[i]) begin
                    return blk_readdata[i];
                end
            end
            return '0;                          // Nothing selected
        end
        case (adr[3:0])
            CSR_STATUS:  return {12'b0, ~pins[5], ~pins[6], pins[7], pins[8]};
            CSR_RST_OVR: return {11'b0, ovr_q};
            CSR_LTRLTD:  return {13'b0, lt_q};
            CSR_SLPBK:   return {15'b0, lb_q};
            default:     return '0;             // Holes
        endcase
    endfunction

    always @(posedge avmm_clk) begin
        if (avmm_reset) begin
            {ovr_q, lt_q, lb_q, busy, ack_q} = '0;
            cycle = 0;
            if (wb_ack !== 1'b0 || chnl.wr !== 1'b0 || chnl.rd !== 1'b0) begin
                mismatch("ack or channel strobe active during reset");
            end
            if (outs !== expected_outs()) begin
                mismatch($sformatf("reset outputs %b, expected %b", outs, expected_outs()));
            end
        end else begin
            cycle++;
            // Shadow only matches the registers between transactions
            if (!busy && outs !== expected_outs()) begin
                mismatch($sformatf("override outputs %b, expected %b", outs, expected_outs()));
            end
            if (wb_ack && ack_q) begin
                mismatch("wb_ack high for two cycles");
            end
            if (chnl.wr || chnl.rd) begin
                strobes++;
                exp_q = expected_data(adr_q);   // Blocks answer in the strobe cycle
                if (!busy || adr_q[11] || {chnl.wr, chnl.rd} != {we_q, !we_q} ||
                    chnl.addr != adr_q[10:0] || (we_q && chnl.wdata != dat_q)) begin
                    mismatch($sformatf("channel bus wr %b rd %b addr %h data %h",
                                       chnl.wr, chnl.rd, chnl.addr, chnl.wdata));
                end
            end
            if (wb_ack && !busy) begin
                mismatch("wb_ack with no open transaction");
            end else if (wb_ack) begin
                busy = 1'b0;                    // Ack edge, stb not taken again
                if (cycle - 1 - acc_cycle != (adr_q[11] ? 3 : 4) ||
                    strobes != (adr_q[11] ? 0 : 1)) begin
                    mismatch($sformatf("address %h acked %0d cycles after accept, %0d strobes",
                                       adr_q, cycle - 1 - acc_cycle, strobes));
                end
                if (adr_q[11]) begin
                    exp_q = expected_data(adr_q);
                end
                if (!we_q && wb_dat_r !== exp_q) begin
                    mismatch($sformatf("read %h from %h, expected %h", wb_dat_r, adr_q, exp_q));
                end
                if (we_q && adr_q[11]) begin
                    case (adr_q[3:0])
                        CSR_RST_OVR: ovr_q = dat_q[4:0];
                        CSR_LTRLTD:  lt_q  = dat_q[2:0];
                        CSR_SLPBK:   lb_q  = dat_q[0];
                        default:     ;          // Status and holes keep nothing
                    endcase
                end
            end else if (wb_cyc && wb_stb && !busy) begin
                {busy, we_q, adr_q, dat_q} = {1'b1, wb_we, wb_adr, wb_dat_w};
                acc_cycle = cycle;
                strobes = 0;
            end
            ack_q = wb_ack;
        end
    end

endmodule

//--- tb_xcvr_reconfig.sv
module tb_xcvr_reconfig;
    timeunit 1ns;
    timeprecision 1ps;
    import xcvr_reconfig_pkg::*;

    localparam int num_blocks = 8;

    logic                              avmm_clk = 1'b0;
    logic                              avmm_reset;
    logic                              wb_cyc, wb_stb, wb_we, wb_ack;
    logic [CHNL_ADDR_W:0]              wb_adr;
    logic [DATA_W-1:0]                 wb_dat_w, wb_dat_r;
    logic                              prbs_done, prbs_err, in_ltr, in_ltd, seriallpbken;
    logic                              in_tx_rst_n, in_rx_rst_n, in_rx_cdr_rst_n, in_rxpma_rst_n;
    logic                              out_tx_rst_n, out_rx_rst_n, out_rx_cdr_rst_n;
    logic                              out_rxpma_rst_n, csr2pcs_ltr, csr2pma_ltd, pma_seriallpbken;
    chnl_bus_t                         chnl;
    logic [num_blocks-1:0]             blk_select;
    logic [num_blocks-1:0][DATA_W-1:0] blk_readdata;
    integer                            seed = 32'h4e18;
    int                                check_errors;
    int                                timeouts = 0;
    int                                rd_count = 0;

    always #10 avmm_clk = ~avmm_clk;            // 20 ns period

    xcvr_reconfig_top #(.num_blocks(num_blocks)) DUT (.*);

    tb_reconfig_checker #(.num_blocks(num_blocks)) u_checker (
        .avmm_clk, .avmm_reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r,
        .wb_ack, .chnl, .blk_select, .blk_readdata,
        .pins   ({prbs_done, prbs_err, in_tx_rst_n, in_rx_rst_n, in_rx_cdr_rst_n,
                  in_rxpma_rst_n, in_ltr, in_ltd, seriallpbken}),
        .outs   ({out_tx_rst_n, out_rx_rst_n, out_rx_cdr_rst_n, out_rxpma_rst_n,
                  csr2pcs_ltr, csr2pma_ltd, pma_seriallpbken}),
        .errors (check_errors)
    );

    // Block model answers inside the strobe cycle, every fourth read selects none
    always @(posedge avmm_clk) begin
        #2;
        if (chnl.rd) begin
            rd_count++;
            blk_select = (rd_count % 4 == 0) ? '0 : num_blocks'($random(seed));
            for (int i = 0; i < num_blocks; i++) begin
                blk_readdata[i] = 16'($random(seed));
            end
        end
    end

    // One classic cycle, held through the ack edge
    task automatic wb_access(input logic we, input logic [11:0] adr, input logic [15:0] dat);
        int waited;
        waited = 0;
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = {2'b11, we, adr, dat};
        do begin
            @(posedge avmm_clk);
            #2;
            waited++;
        end while (!wb_ack && waited < 20);
        if (wb_ack) begin
            @(posedge avmm_clk);
            #2;
        end else begin
            $display("Wishbone acknowledge never arrived for address %h within 20 cycles", adr);
            timeouts++;
        end
        {wb_cyc, wb_stb, wb_we} = 3'b000;
    endtask

    // CSR word address, junk in the undecoded bits
    function automatic logic [11:0] csr_adr(input int idx);
        return {1'b1, 7'h2a, 4'(idx)};
    endfunction

    // New random core-side pins every cycle
    task automatic toggle_pins(input int cycles);
        repeat (cycles) begin
            @(posedge avmm_clk);
            #2;
            {prbs_done, prbs_err, in_tx_rst_n, in_rx_rst_n, in_rx_cdr_rst_n, in_rxpma_rst_n,
             in_ltr, in_ltd, seriallpbken} = 9'($random(seed));
        end
    endtask

    initial begin
        avmm_reset = 1'b1;
        {wb_cyc, wb_stb, wb_we, wb_adr, wb_dat_w} = '0;
        {prbs_done, prbs_err, in_ltr, in_ltd, seriallpbken} = '0;
        {in_tx_rst_n, in_rx_rst_n, in_rx_cdr_rst_n, in_rxpma_rst_n} = '1;   // Resets released
        blk_select = '0;
        blk_readdata = '0;
        repeat (3) @(posedge avmm_clk);
        #2;
        avmm_reset = 1'b0;
        for (int i = 0; i < 5; i++) begin
            wb_access(1'b0, csr_adr(i), '0);    // Reset values, index 4 a hole
        end
        for (int i = 0; i < 8; i++) begin
            wb_access(1'b1, csr_adr(i), 16'hffff);
            wb_access(1'b0, csr_adr(i), '0);    // Masked readback
        end
        toggle_pins(12);                        // Everything forced high, loopback on
        wb_access(1'b1, csr_adr(CSR_RST_OVR), 16'h0015);
        wb_access(1'b1, csr_adr(CSR_LTRLTD), 16'h0003);
        toggle_pins(12);                        // Mixed forced values
        for (int i = 1; i < 4; i++) begin
            wb_access(1'b1, csr_adr(i), '0);
        end
        toggle_pins(12);                        // Pass-through again
        for (int i = 0; i < 16; i++) begin
            {prbs_done, prbs_err, in_tx_rst_n, in_rx_rst_n} = 4'(i);
            wb_access(1'b0, csr_adr(CSR_STATUS), '0);
        end
        // Hard channel side, bit 11 clear
        for (int i = 0; i < 8; i++) begin
            wb_access(1'b1, 12'($random(seed)) & 12'h7ff, 16'($random(seed)));
            wb_access(1'b0, 12'($random(seed)) & 12'h7ff, '0);
        end
        repeat (2) @(posedge avmm_clk);
        $display("check errors %0d, ack timeouts %0d", check_errors, timeouts);
        if (check_errors == 0 && timeouts == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- filelist.f
xcvr_reconfig_pkg.sv
reconfig_req_decode.sv
reconfig_csr_regs.sv
chnl_bus_bridge.sv
reconfig_resp_return.sv
xcvr_reconfig_top.sv
tb_reconfig_checker.sv
tb_xcvr_reconfig.sv
